//--- design/memPkg.sv
`default_nettype none

package memPkg;

  // width of a data word and of the memory read port
  localparam int XLEN = 64;

  // width of one fetched instruction
  localparam int INSTR_W = 32;

  // load and store opcodes
  // the opcode alone fixes the access width and, for loads, the extension
  typedef enum logic [3:0] {
    opLb,
    opLh,
    opLw,
    opLd,
    opLbu,
    opLhu,
    opLwu,
    opSb,
    opSh,
    opSw,
    opSd
  } memOpE;

  // number of bytes in an access, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    sizeByte,
    sizeHalf,
    sizeWord,
    sizeDouble
  } accessSizeE;

  // fetch FSM states
  typedef enum logic {
    fetchIdle,
    fetchWait
  } fetchStateE;

  // load/store FSM states
  typedef enum logic {
    lsuIdle,
    lsuWait
  } lsuStateE;

endpackage

`default_nettype wire

//--- design/unifiedMemory.sv
`timescale 1ns/1ns
`default_nettype none

module unifiedMemory #(
  parameter int MEM_BYTES = 2048,
  parameter int ADDR_W    = 11
) (
  input  logic                       clk,
  input  logic [ADDR_W-1:0]          addr,
  input  logic                       writeEn,
  input  memPkg::accessSizeE         writeSize,
  input  logic [memPkg::XLEN-1:0]    writeData,
  output logic [memPkg::XLEN-1:0]    readData
);

  // one byte per location, shared by instructions and data
  logic [7:0] mem [MEM_BYTES];

  // address of each of the eight byte lanes
  // the sum is truncated to ADDR_W bits, so it wraps at the end of memory
  logic [ADDR_W-1:0] laneAddr [8];

  // number of bytes taken by the current write
  int writeBytes;

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      laneAddr[i] = addr + ADDR_W'(i);
    end
  end

  // big-endian read, the byte at addr lands in the top byte of readData
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      readData[memPkg::XLEN-1-8*i -: 8] = mem[laneAddr[i]];
    end
  end

  // the size enum holds log2 of the byte count
  always_comb begin
    writeBytes = 1 << writeSize;
  end

  // a write stores the low writeBytes bytes of writeData
  // the most significant of those bytes goes to addr and the rest follow it
  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int i = 0; i < 8; i++) begin
        if (i < writeBytes) begin
          mem[laneAddr[i]] <= writeData[8*(writeBytes-1-i) +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/memArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memArbiter #(
  parameter int ADDR_W = 11
) (
  // fetch side, read only
  input  logic                       fetchMemReq,
  input  logic [ADDR_W-1:0]          fetchAddr,

  // load/store side
  input  logic                       lsuMemReq,
  input  logic [ADDR_W-1:0]          lsuAddr,
  input  logic                       lsuWriteEn,
  input  memPkg::accessSizeE         lsuWriteSize,
  input  logic [memPkg::XLEN-1:0]    lsuWriteData,

  // grants back to the units
  output logic                       fetchGrant,
  output logic                       lsuGrant,

  // single memory port
  output logic [ADDR_W-1:0]          memAddr,
  output logic                       memWriteEn,
  output memPkg::accessSizeE         memWriteSize,
  output logic [memPkg::XLEN-1:0]    memWriteData
);

  // the load/store unit always wins, so data accesses never wait
  // a fetch only gets the port in a cycle with no data access
  assign lsuGrant   = lsuMemReq;
  assign fetchGrant = fetchMemReq & ~lsuMemReq;

  // the winner's address goes to the memory in the same cycle
  always_comb begin
    if (lsuGrant) begin
      memAddr = lsuAddr;
    end else begin
      memAddr = fetchAddr;
    end
  end

  // writes only come from the load/store unit
  // qualifying with its grant keeps a fetch cycle from ever writing
  assign memWriteEn = lsuWriteEn & lsuGrant;

  // size and data only matter while memWriteEn is high,
  // and then they always belong to the load/store unit
  assign memWriteSize = lsuWriteSize;
  assign memWriteData = lsuWriteData;

endmodule

`default_nettype wire

//--- design/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
  parameter int ADDR_W   = 11,
  parameter int RESET_PC = 1024
) (
  input  logic                          clk,
  input  logic                          arstN,

  // requests from outside
  input  logic                          fetchReq,
  input  logic                          redirect,
  input  logic [ADDR_W-1:0]             redirectPc,
  output logic                          fetchBusy,

  // memory side through the arbiter
  output logic                          memReq,
  output logic [ADDR_W-1:0]             memAddr,
  input  logic                          memGrant,
  input  logic [memPkg::XLEN-1:0]       memReadData,

  // fetched instruction
  output logic [memPkg::INSTR_W-1:0]    instr,
  output logic [ADDR_W-1:0]             instrPc,
  output logic                          instrValid
);

  memPkg::fetchStateE state;

  // program counter, always the address of the next fetch
  logic [ADDR_W-1:0] pc;

  // the fetch completes at the edge that ends its granted cycle
  logic fetchDone;

  assign fetchDone = (state == memPkg::fetchWait) && memGrant;

  // request stays up until the arbiter grants it
  assign memReq    = (state == memPkg::fetchWait);
  assign memAddr   = pc;
  assign fetchBusy = (state != memPkg::fetchIdle);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= memPkg::fetchIdle;
      pc         <= ADDR_W'(RESET_PC);
      instrValid <= 1'b0;
    end else begin
      instrValid <= 1'b0;
      case (state)
        memPkg::fetchIdle: begin
          // a redirect in the same cycle as fetchReq makes the fetch
          // start from the new address
          if (redirect) begin
            pc <= redirectPc;
          end
          if (fetchReq) begin
            state <= memPkg::fetchWait;
          end
        end
        memPkg::fetchWait: begin
          // hold here while the load/store unit owns the port
          if (memGrant) begin
            state      <= memPkg::fetchIdle;
            pc         <= pc + ADDR_W'(4);
            instrValid <= 1'b1;
          end
        end
        default: begin
          state <= memPkg::fetchIdle;
        end
      endcase
    end
  end

  // the four bytes at pc sit in the top half of the big-endian read word
  always_ff @(posedge clk) begin
    if (fetchDone) begin
      instr   <= memReadData[memPkg::XLEN-1 -: memPkg::INSTR_W];
      instrPc <= pc;
    end
  end

endmodule

`default_nettype wire

//--- design/loadStoreUnit.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit #(
  parameter int ADDR_W = 11
) (
  input  logic                       clk,
  input  logic                       arstN,

  // operation from outside
  input  logic                       lsuStart,
  input  memPkg::memOpE              lsuOp,
  input  logic [ADDR_W-1:0]          lsuAddr,
  input  logic [memPkg::XLEN-1:0]    storeData,
  output logic                       lsuBusy,

  // memory side through the arbiter
  output logic                       memReq,
  output logic [ADDR_W-1:0]          memAddr,
  output logic                       memWriteEn,
  output memPkg::accessSizeE         memWriteSize,
  output logic [memPkg::XLEN-1:0]    memWriteData,
  input  logic                       memGrant,
  input  logic [memPkg::XLEN-1:0]    memReadData,

  // result
  output logic [memPkg::XLEN-1:0]    loadData,
  output logic                       lsuDone
);

  memPkg::lsuStateE state;

  // operation captured at lsuStart
  memPkg::memOpE               opReg;
  logic [ADDR_W-1:0]           addrReg;
  logic [memPkg::XLEN-1:0]     storeDataReg;

  // decoded from the registered opcode
  memPkg::accessSizeE          accessSize;
  logic                        isStore;
  logic                        signExt;

  // loaded value after width selection and extension
  logic [memPkg::XLEN-1:0]     loadValue;

  always_comb begin
    isStore = 1'b0;
    signExt = 1'b0;
    case (opReg)
      memPkg::opLb:  begin accessSize = memPkg::sizeByte;   signExt = 1'b1; end
      memPkg::opLh:  begin accessSize = memPkg::sizeHalf;   signExt = 1'b1; end
      memPkg::opLw:  begin accessSize = memPkg::sizeWord;   signExt = 1'b1; end
      memPkg::opLbu: accessSize = memPkg::sizeByte;
      memPkg::opLhu: accessSize = memPkg::sizeHalf;
      memPkg::opLwu: accessSize = memPkg::sizeWord;
      memPkg::opSb:  begin accessSize = memPkg::sizeByte;   isStore = 1'b1; end
      memPkg::opSh:  begin accessSize = memPkg::sizeHalf;   isStore = 1'b1; end
      memPkg::opSw:  begin accessSize = memPkg::sizeWord;   isStore = 1'b1; end
      memPkg::opSd:  begin accessSize = memPkg::sizeDouble; isStore = 1'b1; end
      // opLd and any unused code read the full doubleword
      default:       accessSize = memPkg::sizeDouble;
    endcase
  end

  // the addressed bytes are always at the top of the big-endian read word
  always_comb begin
    case (accessSize)
      memPkg::sizeByte: begin
        loadValue = {{(memPkg::XLEN-8){signExt & memReadData[memPkg::XLEN-1]}},
                     memReadData[memPkg::XLEN-1 -: 8]};
      end
      memPkg::sizeHalf: begin
        loadValue = {{(memPkg::XLEN-16){signExt & memReadData[memPkg::XLEN-1]}},
                     memReadData[memPkg::XLEN-1 -: 16]};
      end
      memPkg::sizeWord: begin
        loadValue = {{(memPkg::XLEN-32){signExt & memReadData[memPkg::XLEN-1]}},
                     memReadData[memPkg::XLEN-1 -: 32]};
      end
      default: begin
        loadValue = memReadData;
      end
    endcase
  end

  // one memory cycle per operation, the arbiter grants it at once
  assign memReq       = (state == memPkg::lsuWait);
  assign memAddr      = addrReg;
  assign memWriteEn   = memReq & isStore;
  assign memWriteSize = accessSize;
  assign memWriteData = storeDataReg;
  assign lsuBusy      = (state != memPkg::lsuIdle);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= memPkg::lsuIdle;
      lsuDone <= 1'b0;
    end else begin
      lsuDone <= 1'b0;
      case (state)
        memPkg::lsuIdle: begin
          if (lsuStart) begin
            state <= memPkg::lsuWait;
          end
        end
        memPkg::lsuWait: begin
          if (memGrant) begin
            state   <= memPkg::lsuIdle;
            lsuDone <= 1'b1;
          end
        end
        default: begin
          state <= memPkg::lsuIdle;
        end
      endcase
    end
  end

  // operands are taken only while idle, so they hold through the access
  always_ff @(posedge clk) begin
    if ((state == memPkg::lsuIdle) && lsuStart) begin
      opReg        <= lsuOp;
      addrReg      <= lsuAddr;
      storeDataReg <= storeData;
    end
  end

  // a store leaves the last loaded value in place
  always_ff @(posedge clk) begin
    if ((state == memPkg::lsuWait) && memGrant && !isStore) begin
      loadData <= loadValue;
    end
  end

endmodule

`default_nettype wire

//--- design/memSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystem #(
  parameter int MEM_BYTES = 2048,
  parameter int ADDR_W    = 11,
  parameter int RESET_PC  = 1024
) (
  input  logic                          clk,
  input  logic                          arstN,

  // fetch interface
  input  logic                          fetchReq,
  input  logic                          redirect,
  input  logic [ADDR_W-1:0]             redirectPc,
  output logic                          fetchBusy,
  output logic [memPkg::INSTR_W-1:0]    instr,
  output logic [ADDR_W-1:0]             instrPc,
  output logic                          instrValid,

  // load/store interface
  input  logic                          lsuStart,
  input  memPkg::memOpE                 lsuOp,
  input  logic [ADDR_W-1:0]             lsuAddr,
  input  logic [memPkg::XLEN-1:0]       storeData,
  output logic                          lsuBusy,
  output logic [memPkg::XLEN-1:0]       loadData,
  output logic                          lsuDone
);

  // fetch unit to arbiter
  logic                        fetchMemReq;
  logic [ADDR_W-1:0]           fetchMemAddr;
  logic                        fetchGrant;

  // load/store unit to arbiter
  logic                        lsuMemReq;
  logic [ADDR_W-1:0]           lsuMemAddr;
  logic                        lsuWriteEn;
  memPkg::accessSizeE          lsuWriteSize;
  logic [memPkg::XLEN-1:0]     lsuWriteData;
  logic                        lsuGrant;

  // arbiter to memory, read data goes back to both units
  logic [ADDR_W-1:0]           memAddr;
  logic                        memWriteEn;
  memPkg::accessSizeE          memWriteSize;
  logic [memPkg::XLEN-1:0]     memWriteData;
  logic [memPkg::XLEN-1:0]     memReadData;

  fetchUnit #(
    .ADDR_W   (ADDR_W),
    .RESET_PC (RESET_PC)
  ) u_fetchUnit (
    .clk         (clk),
    .arstN       (arstN),
    .fetchReq    (fetchReq),
    .redirect    (redirect),
    .redirectPc  (redirectPc),
    .fetchBusy   (fetchBusy),
    .memReq      (fetchMemReq),
    .memAddr     (fetchMemAddr),
    .memGrant    (fetchGrant),
    .memReadData (memReadData),
    .instr       (instr),
    .instrPc     (instrPc),
    .instrValid  (instrValid)
  );

  loadStoreUnit #(
    .ADDR_W (ADDR_W)
  ) u_loadStoreUnit (
    .clk          (clk),
    .arstN        (arstN),
    .lsuStart     (lsuStart),
    .lsuOp        (lsuOp),
    .lsuAddr      (lsuAddr),
    .storeData    (storeData),
    .lsuBusy      (lsuBusy),
    .memReq       (lsuMemReq),
    .memAddr      (lsuMemAddr),
    .memWriteEn   (lsuWriteEn),
    .memWriteSize (lsuWriteSize),
    .memWriteData (lsuWriteData),
    .memGrant     (lsuGrant),
    .memReadData  (memReadData),
    .loadData     (loadData),
    .lsuDone      (lsuDone)
  );

  memArbiter #(
    .ADDR_W (ADDR_W)
  ) u_memArbiter (
    .fetchMemReq  (fetchMemReq),
    .fetchAddr    (fetchMemAddr),
    .lsuMemReq    (lsuMemReq),
    .lsuAddr      (lsuMemAddr),
    .lsuWriteEn   (lsuWriteEn),
    .lsuWriteSize (lsuWriteSize),
    .lsuWriteData (lsuWriteData),
    .fetchGrant   (fetchGrant),
    .lsuGrant     (lsuGrant),
    .memAddr      (memAddr),
    .memWriteEn   (memWriteEn),
    .memWriteSize (memWriteSize),
    .memWriteData (memWriteData)
  );

  unifiedMemory #(
    .MEM_BYTES (MEM_BYTES),
    .ADDR_W    (ADDR_W)
  ) u_unifiedMemory (
    .clk       (clk),
    .addr      (memAddr),
    .writeEn   (memWriteEn),
    .writeSize (memWriteSize),
    .writeData (memWriteData),
    .readData  (memReadData)
  );

endmodule

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arstN
);

  // free running clock, first rising edge half a period after time 0
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset is low from time 0 and released on a rising edge
  initial begin
    arstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

`default_nettype wire

//--- test/memSubsystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystemTb;

  localparam int MEM_BYTES = 2048;
  localparam int ADDR_W = 11;
  localparam int RESET_PC = 1024;
  localparam int REDIRECT_PC = 512;
  localparam int CLK_PERIOD = 20;
  localparam int ROUNDS = 6;
  localparam int PROG_WORDS = 16;
  localparam int JUMP_WORDS = 8;
  localparam int MIXED_LOADS = 30;
  localparam int LSU_TIMEOUT = 20;
  localparam int FETCH_TIMEOUT = 40;

  // operations issued by the fill, width, wrap, latency, program, redirect and mixed tests
  localparam int TOTAL_OPS = MEM_BYTES / 8 + ROUNDS * 32 + 12 + 8 + 2 * PROG_WORDS
                             + 2 * JUMP_WORDS + 1 + 1 + PROG_WORDS + MIXED_LOADS;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 10 + 200;

  logic clk;
  logic arstN;

  // DUT inputs
  logic fetchReq;
  logic redirect;
  logic [ADDR_W-1:0] redirectPc;
  logic lsuStart;
  memPkg::memOpE lsuOp;
  logic [ADDR_W-1:0] lsuAddr;
  logic [memPkg::XLEN-1:0] storeData;

  // DUT outputs
  logic fetchBusy;
  logic [memPkg::INSTR_W-1:0] instr;
  logic [ADDR_W-1:0] instrPc;
  logic instrValid;
  logic lsuBusy;
  logic [memPkg::XLEN-1:0] loadData;
  logic lsuDone;

  // reference copy of the memory, updated whenever a store is issued
  logic [7:0] refMem [MEM_BYTES];

  // expected results, pushed when an operation is issued and popped on its pulse
  logic [63:0] lsuExpValQ [$];
  bit lsuExpChkQ [$];
  memPkg::memOpE lsuExpOpQ [$];
  int lsuExpAddrQ [$];
  logic [31:0] instrExpQ [$];
  int pcExpQ [$];

  memPkg::memOpE storeOps [4] = '{memPkg::opSb, memPkg::opSh, memPkg::opSw, memPkg::opSd};
  memPkg::memOpE loadOps [7] = '{memPkg::opLb, memPkg::opLh, memPkg::opLw, memPkg::opLd,
                                 memPkg::opLbu, memPkg::opLhu, memPkg::opLwu};

  integer seed;
  int errCount = 0;
  int checkCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int testStartErr = 0;
  int cycleCount = 0;
  int lsuStartCycle = -10;
  int fetchStartCycle = -10;
  int delayedFetches = 0;
  int expPc = RESET_PC;
  bit fetchLatencyCheck = 1'b1;
  bit loadSeen = 1'b0;
  logic [63:0] lastLoadExp = '0;

  clockGen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (3)
  ) u_clockGen (
    .clk   (clk),
    .arstN (arstN)
  );

  memSubsystem #(
    .MEM_BYTES (MEM_BYTES),
    .ADDR_W    (ADDR_W),
    .RESET_PC  (RESET_PC)
  ) u_memSubsystem (
    .clk        (clk),
    .arstN      (arstN),
    .fetchReq   (fetchReq),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .fetchBusy  (fetchBusy),
    .instr      (instr),
    .instrPc    (instrPc),
    .instrValid (instrValid),
    .lsuStart   (lsuStart),
    .lsuOp      (lsuOp),
    .lsuAddr    (lsuAddr),
    .storeData  (storeData),
    .lsuBusy    (lsuBusy),
    .loadData   (loadData),
    .lsuDone    (lsuDone)
  );

  // number of bytes moved by an opcode
  function automatic int accessBytes(memPkg::memOpE op);
    case (op)
      memPkg::opLb, memPkg::opLbu, memPkg::opSb: return 1;
      memPkg::opLh, memPkg::opLhu, memPkg::opSh: return 2;
      memPkg::opLw, memPkg::opLwu, memPkg::opSw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic bit isLoadOp(memPkg::memOpE op);
    return !(op inside {memPkg::opSb, memPkg::opSh, memPkg::opSw, memPkg::opSd});
  endfunction

  // big-endian read from the reference memory, wrapping at MEM_BYTES
  // the signed loads copy the top bit of the loaded field upward
  function automatic logic [63:0] expectedLoad(memPkg::memOpE op, int addr);
    int nBytes;
    bit signedLoad;
    logic [63:0] raw;
    nBytes = accessBytes(op);
    signedLoad = op inside {memPkg::opLb, memPkg::opLh, memPkg::opLw};
    raw = '0;
    for (int i = 0; i < nBytes; i++) begin
      raw = (raw << 8) | 64'(refMem[(addr + i) % MEM_BYTES]);
    end
    if (signedLoad && raw[8*nBytes-1]) begin
      raw = raw | (~64'd0 << (8 * nBytes));
    end
    return raw;
  endfunction

  // an instruction is four bytes with the first one on top
  function automatic logic [31:0] expectedInstr(logic [7:0] b0, logic [7:0] b1,
                                                logic [7:0] b2, logic [7:0] b3);
    return {b0, b1, b2, b3};
  endfunction

  // the low bytes of the store data go out most significant first
  task automatic refStore(memPkg::memOpE op, int addr, logic [63:0] data);
    int nBytes;
    nBytes = accessBytes(op);
    for (int i = 0; i < nBytes; i++) begin
      refMem[(addr + i) % MEM_BYTES] = data[8*(nBytes-1-i) +: 8];
    end
  endtask

  // issues one load or store right after a rising edge and waits for lsuDone
  task automatic runLsu(memPkg::memOpE op, int addr, logic [63:0] data);
    int waitCycles;
    logic [63:0] expValue;
    if (isLoadOp(op)) begin
      expValue = expectedLoad(op, addr);
      lsuExpValQ.push_back(expValue);
      lsuExpChkQ.push_back(1'b1);
      lastLoadExp = expValue;
      loadSeen = 1'b1;
    end else begin
      refStore(op, addr, data);
      // a store must leave the previous load result alone
      lsuExpValQ.push_back(lastLoadExp);
      lsuExpChkQ.push_back(loadSeen);
    end
    lsuExpOpQ.push_back(op);
    lsuExpAddrQ.push_back(addr % MEM_BYTES);
    lsuStart <= 1'b1;
    lsuOp <= op;
    lsuAddr <= ADDR_W'(addr);
    storeData <= data;
    @(posedge clk);
    lsuStart <= 1'b0;
    waitCycles = 0;
    while (!lsuDone && waitCycles < LSU_TIMEOUT) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!lsuDone) begin
      $display("no lsuDone pulse for %s at address %h", op.name(), addr % MEM_BYTES);
      errCount++;
    end
  endtask

  // requests one instruction at the expected pc and waits for instrValid
  task automatic runFetch();
    int waitCycles;
    instrExpQ.push_back(expectedInstr(refMem[expPc % MEM_BYTES],
                                      refMem[(expPc + 1) % MEM_BYTES],
                                      refMem[(expPc + 2) % MEM_BYTES],
                                      refMem[(expPc + 3) % MEM_BYTES]));
    pcExpQ.push_back(expPc);
    fetchReq <= 1'b1;
    @(posedge clk);
    fetchReq <= 1'b0;
    waitCycles = 0;
    while (!instrValid && waitCycles < FETCH_TIMEOUT) begin
      @(posedge clk);
      waitCycles++;
    end
    if (!instrValid) begin
      $display("no instrValid pulse for the fetch at pc %h", expPc);
      errCount++;
    end
    expPc = (expPc + 4) % MEM_BYTES;
  endtask

  task automatic runRedirect(int target);
    redirect <= 1'b1;
    redirectPc <= ADDR_W'(target);
    @(posedge clk);
    redirect <= 1'b0;
    expPc = target;
  endtask

  task automatic startTest();
    testStartErr = errCount;
  endtask

  // one extra edge lets the compare process finish the last pulse
  task automatic endTest(string name);
    @(posedge clk);
    testsRun++;
    if (errCount != testStartErr) begin
      testsFailed++;
      $display("%-10s failed with %0d errors", name, errCount - testStartErr);
    end else begin
      $display("%-10s passed", name);
    end
  endtask

  task automatic checkLsuDone();
    int latency;
    logic [63:0] expValue;
    bit checkData;
    memPkg::memOpE op;
    int addr;
    latency = cycleCount - lsuStartCycle;
    checkCount++;
    if (latency != 2) begin
      $display("lsuDone arrived %0d cycles after lsuStart instead of 2", latency);
      errCount++;
    end
    if (lsuExpValQ.size() == 0) begin
      $display("lsuDone pulsed with no operation outstanding");
      errCount++;
    end else begin
      expValue = lsuExpValQ.pop_front();
      checkData = lsuExpChkQ.pop_front();
      op = lsuExpOpQ.pop_front();
      addr = lsuExpAddrQ.pop_front();
      if (checkData && loadData !== expValue) begin
        $display("FAILED loadData expected %h got %h after %s at %h",
                 expValue, loadData, op.name(), addr);
        errCount++;
      end
    end
  endtask

  task automatic checkInstr();
    int latency;
    logic [31:0] expInstr;
    int pc;
    latency = cycleCount - fetchStartCycle;
    checkCount++;
    if (latency > 2) begin
      delayedFetches++;
    end
    if (fetchLatencyCheck && latency != 2) begin
      $display("instrValid arrived %0d cycles after fetchReq instead of 2", latency);
      errCount++;
    end
    if (instrExpQ.size() == 0) begin
      $display("instrValid pulsed with no fetch outstanding");
      errCount++;
    end else begin
      expInstr = instrExpQ.pop_front();
      pc = pcExpQ.pop_front();
      if (instrPc !== ADDR_W'(pc)) begin
        $display("FAILED instrPc expected %h got %h", ADDR_W'(pc), instrPc);
        errCount++;
      end
      if (instr !== expInstr) begin
        $display("FAILED instr expected %h got %h at pc %h", expInstr, instr, pc);
        errCount++;
      end
    end
  endtask

  // the compare process sees the values that were stable before each edge
  always @(posedge clk) begin
    if (arstN) begin
      cycleCount = cycleCount + 1;
      if (lsuStart && !lsuBusy) begin
        lsuStartCycle = cycleCount;
      end
      if (fetchReq && !fetchBusy) begin
        fetchStartCycle = cycleCount;
      end
      // the cycle after an accepted start must show the unit busy
      if (cycleCount == lsuStartCycle + 1 && !lsuBusy) begin
        $display("lsuBusy was low while an access was in flight");
        errCount++;
      end
      if (cycleCount == fetchStartCycle + 1 && !fetchBusy) begin
        $display("fetchBusy was low while a fetch was in flight");
        errCount++;
      end
      if (lsuDone) begin
        checkLsuDone();
      end
      if (instrValid) begin
        checkInstr();
      end
    end
  end

  // watchdog sized from the number of operations in the run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int addr;
    logic [63:0] data;
    seed = 32'h28af_d4b4;
    fetchReq = 1'b0;
    redirect = 1'b0;
    redirectPc = '0;
    lsuStart = 1'b0;
    lsuOp = memPkg::opLd;
    lsuAddr = '0;
    storeData = '0;
    @(posedge arstN);
    @(posedge clk);

    // outputs straight after reset
    startTest();
    checkCount++;
    if (instrValid !== 1'b0 || lsuDone !== 1'b0 || fetchBusy !== 1'b0 || lsuBusy !== 1'b0) begin
      $display("FAILED reset outputs expected 0 got instrValid %h lsuDone %h busy %h %h",
               instrValid, lsuDone, fetchBusy, lsuBusy);
      errCount++;
    end
    endTest("reset");

    // every byte gets a value built from its own address
    startTest();
    for (int a = 0; a < MEM_BYTES; a += 8) begin
      data = {16'hc0de ^ 16'(a), 16'(a), ~16'(a), 16'h3c3c ^ 16'(a)};
      runLsu(memPkg::opSd, a, data);
    end
    endTest("fill");

    // each store width, then every load kind from the same random address
    startTest();
    for (int r = 0; r < ROUNDS; r++) begin
      for (int s = 0; s < 4; s++) begin
        addr = $random(seed) & (MEM_BYTES - 1);
        data = {$random(seed), $random(seed)};
        runLsu(storeOps[s], addr, data);
        for (int l = 0; l < 7; l++) begin
          runLsu(loadOps[l], addr, 64'd0);
        end
      end
    end
    endTest("widths");

    // accesses that run past the last byte continue at address 0
    startTest();
    runLsu(memPkg::opSd, MEM_BYTES - 3, {$random(seed), $random(seed)});
    runLsu(memPkg::opLd, MEM_BYTES - 3, 64'd0);
    runLsu(memPkg::opLbu, 0, 64'd0);
    runLsu(memPkg::opLhu, MEM_BYTES - 1, 64'd0);
    runLsu(memPkg::opLw, MEM_BYTES - 2, 64'd0);
    runLsu(memPkg::opSh, MEM_BYTES - 1, 64'h8765);
    runLsu(memPkg::opLb, 0, 64'd0);
    runLsu(memPkg::opLh, MEM_BYTES - 1, 64'd0);
    runLsu(memPkg::opSw, MEM_BYTES - 1, 64'hfeed_beef);
    runLsu(memPkg::opLwu, MEM_BYTES - 1, 64'd0);
    runLsu(memPkg::opLd, MEM_BYTES - 6, 64'd0);
    runLsu(memPkg::opLd, 0, 64'd0);
    endTest("wrap");

    // the compare process checks the 2 cycle latency of each of these
    startTest();
    for (int i = 0; i < 4; i++) begin
      addr = $random(seed) & (MEM_BYTES - 1);
      runLsu(storeOps[i], addr, {$random(seed), $random(seed)});
      runLsu(loadOps[i], addr, 64'd0);
    end
    endTest("latency");

    // a short program at the reset pc, fetched in order
    startTest();
    for (int i = 0; i < PROG_WORDS; i++) begin
      runLsu(memPkg::opSw, RESET_PC + 4 * i, {32'd0, $random(seed)});
    end
    for (int i = 0; i < PROG_WORDS; i++) begin
      runFetch();
    end
    endTest("program");

    startTest();
    for (int i = 0; i < JUMP_WORDS; i++) begin
      runLsu(memPkg::opSw, REDIRECT_PC + 4 * i, {32'd0, $random(seed)});
    end
    runRedirect(REDIRECT_PC);
    for (int i = 0; i < JUMP_WORDS; i++) begin
      runFetch();
    end
    endTest("redirect");

    // fetches compete with back-to-back loads and memory is not written here
    startTest();
    fetchLatencyCheck = 1'b0;
    delayedFetches = 0;
    runRedirect(RESET_PC);
    fork
      begin
        for (int i = 0; i < PROG_WORDS; i++) begin
          runFetch();
        end
      end
      begin
        for (int i = 0; i < MIXED_LOADS; i++) begin
          runLsu(loadOps[i % 7], $random(seed) & (MEM_BYTES - 1), 64'd0);
        end
      end
    join
    // both units start together, so the first fetch has to lose to a load
    checkCount++;
    if (delayedFetches == 0) begin
      $display("no fetch was held back by a load in the mixed traffic");
      errCount++;
    end
    endTest("mixed");

    repeat (2) @(posedge clk);
    if (lsuExpValQ.size() != 0 || instrExpQ.size() != 0) begin
      $display("%0d load/store and %0d fetch results never arrived",
               lsuExpValQ.size(), instrExpQ.size());
      errCount++;
    end
    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/memPkg.sv
design/unifiedMemory.sv
design/memArbiter.sv
design/fetchUnit.sv
design/loadStoreUnit.sv
design/memSubsystem.sv
test/clockGen.sv
test/memSubsystemTb.sv
